//--- filelist.f
+incdir+verif
verilog/pool_data_pkg.sv
verilog/pool_ctrl_pkg.sv
verilog/pool_ctrl_if.sv
verilog/pool_scheduler.sv
verilog/pool_lane.sv
verilog/pool_collector.sv
verilog/pool_top.sv
verif/tb_pool_top.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the pooling testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal -f filelist.f \
	--top-module tb_pool_top -o sim_pool \
	&& ./obj_dir/sim_pool | tee sim.log \
	&& grep -q "^STATUS: PASS$" sim.log \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }

//--- verif/pool_model.svh
/*
 * Reference model of the pooling stage, included inside the testbench.
 * Holds the stimulus of the current frame and derives the expected
 * output words for pool and bypass mode.
 */

typedef logic [pool_data_pkg::WORD_W-1:0] word_t;

// Stimulus of one frame, per path
word_t stim_3x3 [MAX_PIX];
word_t stim_1x1 [MAX_PIX];

// Expected output words, oldest first
word_t exp_3x3_q [$];
word_t exp_1x1_q [$];

// Channel-wise signed maximum
function automatic word_t word_max(input word_t a, input word_t b);
	word_t m;
	logic signed [pool_data_pkg::CH_W-1:0] ca;
	logic signed [pool_data_pkg::CH_W-1:0] cb;
	for (int c = 0; c < pool_data_pkg::CH_PER_WORD; c++) begin
		ca = a[c*pool_data_pkg::CH_W +: pool_data_pkg::CH_W];
		cb = b[c*pool_data_pkg::CH_W +: pool_data_pkg::CH_W];
		m[c*pool_data_pkg::CH_W +: pool_data_pkg::CH_W] = (ca >= cb) ? ca : cb;
	end
	return m;
endfunction

// Maximum of the 2x2 block whose top left pixel is at base
function automatic word_t block_max(input bit path, input int base);
	if (path) begin
		return word_max(word_max(stim_1x1[base], stim_1x1[base+1]),
		                word_max(stim_1x1[base+IMG_W], stim_1x1[base+IMG_W+1]));
	end
	return word_max(word_max(stim_3x3[base], stim_3x3[base+1]),
	                word_max(stim_3x3[base+IMG_W], stim_3x3[base+IMG_W+1]));
endfunction

// Blocks closed by the first n_sent pixels, or the pixels themselves
task automatic expect_frame(input bit pool, input int rows, input int n_sent);
	int base;
	if (!pool) begin
		for (int i = 0; i < n_sent; i++) begin
			exp_3x3_q.push_back(stim_3x3[i]);
			exp_1x1_q.push_back(stim_1x1[i]);
		end
	end else begin
		for (int br = 0; br < rows / 2; br++) begin
			for (int bc = 0; bc < IMG_W / 2; bc++) begin
				base = 2 * br * IMG_W + 2 * bc;
				// Block closes on its bottom right pixel
				if (base + IMG_W + 1 < n_sent) begin
					exp_3x3_q.push_back(block_max(1'b0, base));
					exp_1x1_q.push_back(block_max(1'b1, base));
				end
			end
		end
	end
endtask

//--- verif/tb_pool_top.sv
/*
 * Testbench of the 2x2 max-pooling stage.
 * Sends random frames in pool and bypass mode, idle pixels and
 * aborted frames, and checks every output word and frame done pulse.
 */

`timescale 1ns/1ns
`default_nettype none

module tb_pool_top;

	localparam int IMG_W      = 16;
	localparam int CLK_NS     = 8;
	localparam int MAX_GAP    = 3;
	localparam int MAX_PIX    = 8 * IMG_W;
	// Upper bound on the pixels strobed over the whole test
	localparam int PIX_BUDGET = 512;
	localparam int WATCH_NS   = PIX_BUDGET * (MAX_GAP + 2) * CLK_NS + 400 * CLK_NS;

	logic                                 clk_i;
	logic                                 rst_n_i;
	logic                                 start_i;
	logic                                 pool_en_i;
	logic [pool_ctrl_pkg::ROWS_W-1:0]     rows_i;
	logic                                 pix_valid_i;
	logic [pool_data_pkg::WORD_W-1:0]     pix_3x3_i;
	logic [pool_data_pkg::WORD_W-1:0]     pix_1x1_i;
	logic                                 out_valid_o;
	logic [pool_data_pkg::WORD_W-1:0]     out_3x3_o;
	logic [pool_data_pkg::WORD_W-1:0]     out_1x1_o;
	logic                                 frame_done_o;

	integer seed;
	int     value_errs;
	int     proto_errs;
	int     done_cnt;
	int     exp_done;

	`include "pool_model.svh"

	word_t e3;
	word_t e1;

	pool_top u_pool_top (
		.clk_i        (clk_i),
		.rst_n_i      (rst_n_i),
		.start_i      (start_i),
		.pool_en_i    (pool_en_i),
		.rows_i       (rows_i),
		.pix_valid_i  (pix_valid_i),
		.pix_3x3_i    (pix_3x3_i),
		.pix_1x1_i    (pix_1x1_i),
		.out_valid_o  (out_valid_o),
		.out_3x3_o    (out_3x3_o),
		.out_1x1_o    (out_1x1_o),
		.frame_done_o (frame_done_o)
	);

	always #(CLK_NS / 2) clk_i = ~clk_i;

	//----------------------------------------------------------------------
	// Stimulus helpers
	//----------------------------------------------------------------------

	// Random channels with extremes on a quarter of them
	function automatic word_t rand_word();
		word_t       w;
		logic [31:0] r;
		for (int c = 0; c < pool_data_pkg::CH_PER_WORD; c++) begin
			r = $random(seed);
			case (r[2:0])
				3'd0:    w[c*pool_data_pkg::CH_W +: pool_data_pkg::CH_W] = 12'h800;
				3'd1:    w[c*pool_data_pkg::CH_W +: pool_data_pkg::CH_W] = 12'h7ff;
				default: w[c*pool_data_pkg::CH_W +: pool_data_pkg::CH_W] = r[19:8];
			endcase
		end
		return w;
	endfunction

	task automatic fill_stim(input int n);
		for (int i = 0; i < n; i++) begin
			stim_3x3[i] = rand_word();
			stim_1x1[i] = rand_word();
		end
	endtask

	task automatic start_frame(input bit pool, input int rows);
		start_i   = 1'b1;
		pool_en_i = pool;
		rows_i    = rows[pool_ctrl_pkg::ROWS_W-1:0];
		@(negedge clk_i);
		start_i   = 1'b0;
	endtask

	// One strobe per pixel with random idle cycles before each
	task automatic send_pixels(input int n);
		int gap;
		for (int i = 0; i < n; i++) begin
			gap = $unsigned($random(seed)) % (MAX_GAP + 1);
			repeat (gap) @(negedge clk_i);
			pix_valid_i = 1'b1;
			pix_3x3_i   = stim_3x3[i];
			pix_1x1_i   = stim_1x1[i];
			@(negedge clk_i);
			pix_valid_i = 1'b0;
		end
	endtask

	task automatic wait_done();
		int cyc;
		cyc = 0;
		while (done_cnt < exp_done && cyc < 4 * IMG_W) begin
			@(negedge clk_i);
			cyc++;
		end
		assert (done_cnt >= exp_done) else begin
			proto_errs++;
			$display("Frame done pulse missing at %0t", $time);
		end
	endtask

	task automatic check_drained();
		assert (exp_3x3_q.size() == 0) else begin
			proto_errs++;
			$display("%0d output words missing at %0t", exp_3x3_q.size(), $time);
			exp_3x3_q.delete();
			exp_1x1_q.delete();
		end
	endtask

	// A frame cut short by the next start when n_sent is below its size
	task automatic run_frame(input bit pool, input int rows, input int n_sent);
		fill_stim(n_sent);
		expect_frame(pool, rows, n_sent);
		if (n_sent == rows * IMG_W) begin
			exp_done++;
		end
		start_frame(pool, rows);
		send_pixels(n_sent);
		if (n_sent == rows * IMG_W) begin
			wait_done();
		end
		repeat (3) @(negedge clk_i);
		check_drained();
	endtask

	//----------------------------------------------------------------------
	// Output monitor on the falling edge
	//----------------------------------------------------------------------

	always @(negedge clk_i) begin
		if (rst_n_i && out_valid_o) begin
			assert (exp_3x3_q.size() > 0) else begin
				proto_errs++;
				$display("Output strobe at %0t with no word expected", $time);
			end
			if (exp_3x3_q.size() > 0) begin
				e3 = exp_3x3_q.pop_front();
				e1 = exp_1x1_q.pop_front();
				assert (out_3x3_o == e3) else begin
					value_errs++;
					$display("Error at %0t: 3x3 word %h, expected %h", $time, out_3x3_o, e3);
				end
				assert (out_1x1_o == e1) else begin
					value_errs++;
					$display("Error at %0t: 1x1 word %h, expected %h", $time, out_1x1_o, e1);
				end
			end
		end
		if (rst_n_i && frame_done_o) begin
			done_cnt++;
			assert (done_cnt <= exp_done) else begin
				proto_errs++;
				$display("Extra frame done pulse at %0t", $time);
			end
			// Done goes with the last word of the frame
			assert (out_valid_o && exp_3x3_q.size() == 0) else begin
				proto_errs++;
				$display("Frame done at %0t not aligned with the last output word", $time);
			end
		end
	end

	// Watchdog
	initial begin
		#(WATCH_NS);
		$display("Watchdog expired at %0t, the test did not finish", $time);
		$display("STATUS: FAIL");
		$finish;
	end

	initial begin
		seed        = 32'hda88_e896;
		clk_i       = 1'b0;
		rst_n_i     = 1'b0;
		start_i     = 1'b0;
		pool_en_i   = 1'b0;
		rows_i      = '0;
		pix_valid_i = 1'b0;
		pix_3x3_i   = '0;
		pix_1x1_i   = '0;
		value_errs  = 0;
		proto_errs  = 0;
		done_cnt    = 0;
		exp_done    = 0;
		repeat (3) @(negedge clk_i);
		rst_n_i = 1'b1;
		@(negedge clk_i);

		// Pixels before any start are dropped
		fill_stim(6);
		send_pixels(6);
		repeat (3) @(negedge clk_i);

		run_frame(1'b1, 2, 2 * IMG_W);
		run_frame(1'b1, 4, 4 * IMG_W);
		run_frame(1'b0, 2, 2 * IMG_W);
		run_frame(1'b1, 8, 8 * IMG_W);
		// Abort inside the second row and follow with a clean pooled frame
		run_frame(1'b1, 6, IMG_W + 5);
		run_frame(1'b1, 4, 4 * IMG_W);
		run_frame(1'b0, 4, 10);
		run_frame(1'b0, 2, 2 * IMG_W);

		// Pixels after a finished frame are dropped
		fill_stim(5);
		send_pixels(5);
		repeat (4) @(negedge clk_i);

		$display("Test done: %0d value errors, %0d protocol errors", value_errs, proto_errs);
		if (value_errs == 0 && proto_errs == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog/pool_top.sv
/*
 * Top level of the 2x2 max-pooling stage.
 * Plain strobe ports for the 3x3 and 1x1 feature paths; inside,
 * a scheduler drives one lane per path and a collector merges
 * the results with the bypass data.
 */

`timescale 1ns/1ns
`default_nettype none

module pool_top #(
	parameter int IMG_W = 16
) (
	input  wire logic                              clk_i,
	input  wire logic                              rst_n_i,
	input  wire logic                              start_i,
	input  wire logic                              pool_en_i,
	input  wire logic [pool_ctrl_pkg::ROWS_W-1:0]  rows_i,
	input  wire logic                              pix_valid_i,
	input  wire logic [pool_data_pkg::WORD_W-1:0]  pix_3x3_i,
	input  wire logic [pool_data_pkg::WORD_W-1:0]  pix_1x1_i,
	output logic                                   out_valid_o,
	output logic [pool_data_pkg::WORD_W-1:0]       out_3x3_o,
	output logic [pool_data_pkg::WORD_W-1:0]       out_1x1_o,
	output logic                                   frame_done_o
);

	pool_ctrl_if ctrl_if ();

	pool_data_pkg::path_words_t              pix_words;
	pool_data_pkg::path_words_t              res_words;
	pool_data_pkg::path_words_t              out_words;
	logic [pool_data_pkg::NUM_PATHS-1:0]     res_valid;
	logic                                    pool_en;

	// Path ports to path array
	assign pix_words[0] = pix_3x3_i;
	assign pix_words[1] = pix_1x1_i;

	pool_scheduler #(
		.IMG_W       (IMG_W)
	) u_scheduler (
		.clk_i       (clk_i),
		.rst_n_i     (rst_n_i),
		.start_i     (start_i),
		.pool_en_i   (pool_en_i),
		.rows_i      (rows_i),
		.pix_valid_i (pix_valid_i),
		.ctrl        (ctrl_if.sched),
		.pool_en_o   (pool_en)
	);

	// One lane per feature path
	for (genvar gi = 0; gi < pool_data_pkg::NUM_PATHS; gi++) begin : g_lane
		pool_lane #(
			.IMG_W       (IMG_W)
		) u_lane (
			.clk_i       (clk_i),
			.rst_n_i     (rst_n_i),
			.ctrl        (ctrl_if.lane),
			.pix_i       (pix_words[gi]),
			.res_o       (res_words[gi]),
			.res_valid_o (res_valid[gi])
		);
	end

	// Lanes run in lock step, lane 0 valid stands for all
	pool_collector u_collector (
		.clk_i        (clk_i),
		.rst_n_i      (rst_n_i),
		.pool_en_i    (pool_en),
		.pix_valid_i  (ctrl_if.cmd_valid),
		.pix_i        (pix_words),
		.last_pix_i   (ctrl_if.last_pix),
		.res_i        (res_words),
		.res_valid_i  (res_valid[0]),
		.out_o        (out_words),
		.out_valid_o  (out_valid_o),
		.frame_done_o (frame_done_o)
	);

	assign out_3x3_o = out_words[0];
	assign out_1x1_o = out_words[1];

endmodule

`default_nettype wire

//--- verilog/pool_collector.sv
/*
 * Output stage of the pooling block.
 * In bypass mode it registers every accepted pixel; in pool mode
 * it forwards the lane results unchanged. Also turns the
 * last-pixel flag into the end-of-frame pulse.
 */

`timescale 1ns/1ns
`default_nettype none

module pool_collector (
	input  wire logic                  clk_i,
	input  wire logic                  rst_n_i,
	input  wire logic                  pool_en_i,
	input  wire logic                  pix_valid_i,
	input  pool_data_pkg::path_words_t pix_i,
	input  wire logic                  last_pix_i,
	input  pool_data_pkg::path_words_t res_i,
	input  wire logic                  res_valid_i,
	output pool_data_pkg::path_words_t out_o,
	output logic                       out_valid_o,
	output logic                       frame_done_o
);

	// Bypass copy, one cycle behind the pixel
	pool_data_pkg::path_words_t byp_q;
	logic                       byp_valid_q;

	//----------------------------------------------------------------------
	// Bypass path
	//----------------------------------------------------------------------

	always_ff @(posedge clk_i) begin
		if (pix_valid_i) begin
			byp_q <= pix_i;
		end
	end

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			byp_valid_q <= 1'b0;
		end else begin
			byp_valid_q <= pix_valid_i;
		end
	end

	//----------------------------------------------------------------------
	// Output select and frame end
	//----------------------------------------------------------------------

	// Lane results are already registered, no extra stage
	assign out_o       = pool_en_i ? res_i : byp_q;
	assign out_valid_o = pool_en_i ? res_valid_i : byp_valid_q;

	// Lines up with the last output word in both modes
	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			frame_done_o <= 1'b0;
		end else begin
			frame_done_o <= last_pix_i;
		end
	end

endmodule

`default_nettype wire

//--- verilog/pool_lane.sv
/*
 * One pooling path.
 * Keeps the even pixel of each pair, stores the pair maxima of
 * even rows in a line buffer and folds them with the odd row to
 * give one registered 2x2 maximum per block.
 */

`timescale 1ns/1ns
`default_nettype none

module pool_lane #(
	parameter int IMG_W = 16
) (
	input  wire logic                 clk_i,
	input  wire logic                 rst_n_i,
	pool_ctrl_if.lane                 ctrl,
	input  pool_data_pkg::pool_word_t pix_i,
	output pool_data_pkg::pool_word_t res_o,
	output logic                      res_valid_o
);

	localparam int DEPTH = IMG_W / 2;
	localparam int AW    = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	// Pair register and line buffer of pair maxima
	pool_data_pkg::pool_word_t pair_q;
	pool_data_pkg::pool_word_t line_buf [DEPTH];
	logic [AW-1:0]             addr;

	pool_data_pkg::pool_word_t pair_max;
	pool_data_pkg::pool_word_t blk_max;

	// Signed maximum per channel
	function automatic pool_data_pkg::pool_word_t lane_max(
		input pool_data_pkg::pool_word_t a,
		input pool_data_pkg::pool_word_t b
	);
		pool_data_pkg::pool_word_t m;
		for (int i = 0; i < pool_data_pkg::CH_PER_WORD; i++) begin
			m[i] = ($signed(a[i]) > $signed(b[i])) ? a[i] : b[i];
		end
		return m;
	endfunction

	assign addr     = ctrl.buf_addr[AW-1:0];
	assign pair_max = lane_max(pair_q, pix_i);
	assign blk_max  = lane_max(pair_max, line_buf[addr]);

	// Even column: hold the first pixel of the pair
	always_ff @(posedge clk_i) begin
		if (ctrl.cmd_valid && !ctrl.col_odd) begin
			pair_q <= pix_i;
		end
	end

	// Even row, odd column: park the pair maximum
	always_ff @(posedge clk_i) begin
		if (ctrl.cmd_valid && ctrl.col_odd && !ctrl.row_odd) begin
			line_buf[addr] <= pair_max;
		end
	end

	// Odd row, odd column: block complete
	always_ff @(posedge clk_i) begin
		if (ctrl.cmd_valid && ctrl.col_odd && ctrl.row_odd) begin
			res_o <= blk_max;
		end
	end

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			res_valid_o <= 1'b0;
		end else begin
			res_valid_o <= ctrl.cmd_valid && ctrl.col_odd && ctrl.row_odd;
		end
	end

endmodule

`default_nettype wire

//--- verilog/pool_scheduler.sv
/*
 * Row scheduler of the pooling stage.
 * Latches mode and row count on start_i, counts columns and rows,
 * and turns each accepted pixel into a command for the lanes in
 * the same cycle.
 */

`timescale 1ns/1ns
`default_nettype none

module pool_scheduler #(
	parameter int IMG_W = 16
) (
	input  wire logic                              clk_i,
	input  wire logic                              rst_n_i,
	input  wire logic                              start_i,
	input  wire logic                              pool_en_i,
	input  wire logic [pool_ctrl_pkg::ROWS_W-1:0]  rows_i,
	input  wire logic                              pix_valid_i,
	pool_ctrl_if.sched                             ctrl,
	output logic                                   pool_en_o
);

	localparam int CW = pool_ctrl_pkg::COL_W;
	localparam logic [CW-1:0] LAST_COL = CW'(IMG_W - 1);

	// Latched configuration
	logic                              pool_en_q;
	logic [pool_ctrl_pkg::ROWS_W-1:0]  rows_q;

	// Position within the frame
	pool_ctrl_pkg::pool_state_e        state_q;
	logic [CW-1:0]                     col_q;
	logic [pool_ctrl_pkg::ROWS_W-1:0]  row_q;

	logic                              accept;
	logic                              row_end;
	logic                              frame_end;

	//----------------------------------------------------------------------
	// Pixel acceptance
	//----------------------------------------------------------------------

	// Idle pixels dropped; a start cycle belongs to no frame
	assign accept    = pix_valid_i && !start_i && (state_q != pool_ctrl_pkg::IDLE);
	assign row_end   = accept && (col_q == LAST_COL);
	assign frame_end = row_end && (row_q == rows_q - 1'b1);

	// Configuration, only on start
	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			pool_en_q <= 1'b0;
			rows_q    <= '0;
		end else if (start_i) begin
			pool_en_q <= pool_en_i;
			rows_q    <= rows_i;
		end
	end

	//----------------------------------------------------------------------
	// Row FSM and counters
	//----------------------------------------------------------------------

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			state_q <= pool_ctrl_pkg::IDLE;
			col_q   <= '0;
			row_q   <= '0;
		end else if (start_i) begin
			// Also aborts a frame in flight
			state_q <= pool_ctrl_pkg::EVEN_ROW;
			col_q   <= '0;
			row_q   <= '0;
		end else if (accept) begin
			col_q <= row_end ? '0 : col_q + 1'b1;
			if (row_end) begin
				row_q <= row_q + 1'b1;
				case (state_q)
					pool_ctrl_pkg::EVEN_ROW: state_q <= pool_ctrl_pkg::ODD_ROW;
					pool_ctrl_pkg::ODD_ROW:  state_q <= frame_end ? pool_ctrl_pkg::IDLE
					                                              : pool_ctrl_pkg::EVEN_ROW;
					default:                 state_q <= pool_ctrl_pkg::IDLE;
				endcase
			end
		end
	end

	//----------------------------------------------------------------------
	// Command to the lanes
	//----------------------------------------------------------------------

	assign ctrl.cmd_valid = accept;
	assign ctrl.col_odd   = col_q[0];
	assign ctrl.row_odd   = (state_q == pool_ctrl_pkg::ODD_ROW);
	// Pair index is the column halved
	assign ctrl.buf_addr  = col_q[CW-1:1];
	assign ctrl.last_pix  = frame_end;

	assign pool_en_o = pool_en_q;

endmodule

`default_nettype wire

//--- verilog/pool_ctrl_if.sv
/*
 * Per-pixel pooling command from the scheduler to every lane.
 * All signals are valid in the cycle of the accepted pixel and
 * are shared by the lanes of both feature paths.
 */

`timescale 1ns/1ns
`default_nettype none

interface pool_ctrl_if;

	// Accepted pixel strobe
	logic                              cmd_valid;

	// Pixel closes a horizontal pair
	logic                              col_odd;

	// Pixel sits in the second row of a row pair
	logic                              row_odd;

	// Pair index within the row, selects the line buffer entry
	logic [pool_ctrl_pkg::COL_W-2:0]   buf_addr;

	// Final pixel of the frame
	logic                              last_pix;

	modport sched (
		output cmd_valid,
		output col_odd,
		output row_odd,
		output buf_addr,
		output last_pix
	);

	modport lane (
		input  cmd_valid,
		input  col_odd,
		input  row_odd,
		input  buf_addr,
		input  last_pix
	);

endinterface

`default_nettype wire

//--- verilog/pool_ctrl_pkg.sv
/*
 * Control definitions for the pooling stage.
 * Holds the scheduler state encoding and the widths that bound
 * the frame geometry (rows per frame, pixels per row).
 */

`default_nettype none

package pool_ctrl_pkg;

	// Row state of the scheduler FSM
	typedef enum logic [1:0] {
		IDLE     = 2'b00,
		EVEN_ROW = 2'b01,
		ODD_ROW  = 2'b10
	} pool_state_e;

	// Row count configuration width
	localparam int ROWS_W = 8;

	// Column counter width, so IMG_W is at most 256
	localparam int COL_W  = 8;

endpackage

`default_nettype wire

//--- verilog/pool_data_pkg.sv
/*
 * Word format shared by the pooling datapath.
 * Each word packs four signed channel values; two feature paths
 * (3x3 and 1x1) are pooled side by side.
 */

`default_nettype none

package pool_data_pkg;

	// Channel and word geometry
	localparam int CH_W        = 12;
	localparam int CH_PER_WORD = 4;
	localparam int WORD_W      = CH_W * CH_PER_WORD;

	// Path 0 is 3x3, path 1 is 1x1
	localparam int NUM_PATHS   = 2;

	// One word, channel 0 in the low bits
	typedef logic [CH_PER_WORD-1:0][CH_W-1:0] pool_word_t;

	// All paths of one pixel or one pooled block
	typedef pool_word_t [NUM_PATHS-1:0] path_words_t;

endpackage

`default_nettype wire
